//--- verilog/dma_frontend_pkg.sv
package dma_frontend_pkg;

    // width of a transfer id as seen by the PEs
    localparam int unsigned TransferIdWidth = 28;

    // serialize and decouple set, deburst clear
    localparam logic [2:0] ConfResetValue = 3'b101;

    // one copy job as handed to the backend
    typedef struct packed {
        logic [31:0] num_bytes;
        logic [31:0] dst_addr;
        logic [31:0] src_addr;
        logic        decouple;
        logic        deburst;
        logic        serialize;
    } transf_descr_t;

    // request type on the ctrl port
    typedef enum logic {
        CTRL_WRITE = 1'b0,
        CTRL_READ  = 1'b1
    } ctrl_op_e;

    // register offsets within one PE's window
    typedef enum logic [7:0] {
        REG_SRC     = 8'h00,
        REG_DST     = 8'h08,
        REG_NUM     = 8'h10,
        REG_CONF    = 8'h18,
        REG_NEXT_ID = 8'h20,
        REG_DONE_ID = 8'h28
    } reg_offset_e;

    // copy engine states
    typedef enum logic [1:0] {
        ENG_IDLE,
        ENG_READ,
        ENG_WRITE
    } eng_state_e;

endpackage

//--- verilog/dma_frontend_regs.sv
`timescale 1ns/1ps

module dma_frontend_regs (
    input  logic                                         clk_i,
    input  logic                                         rst_ni,
    input  logic                                         ctrl_req_i,
    input  dma_frontend_pkg::ctrl_op_e                   ctrl_type_i,
    input  logic [3:0]                                   ctrl_be_i,
    input  logic [31:0]                                  ctrl_add_i,
    input  logic [31:0]                                  ctrl_data_i,
    output logic                                         ctrl_gnt_o,
    output logic                                         ctrl_valid_o,
    output logic [31:0]                                  ctrl_data_o,
    input  logic [dma_frontend_pkg::TransferIdWidth-1:0] next_id_i,
    input  logic [dma_frontend_pkg::TransferIdWidth-1:0] done_id_i,
    input  logic                                         busy_i,
    input  logic                                         launch_grant_i,
    output logic                                         launch_valid_o,
    output dma_frontend_pkg::transf_descr_t              descr_o
);

    import dma_frontend_pkg::*;

    localparam int unsigned IdPad = 32 - TransferIdWidth;

    logic [7:0]  reg_addr;
    logic        is_read;
    logic [31:0] src_d, src_q;
    logic [31:0] dst_d, dst_q;
    logic [31:0] num_d, num_q;
    logic [2:0]  conf_d, conf_q;
    // response is returned one cycle after acceptance
    logic [31:0] rdata_d, rdata_q;
    logic        valid_d, valid_q;

    // byte-wise merge of a write into a stored word
    function automatic logic [31:0] merge_be(input logic [31:0] old_word,
                                             input logic [31:0] new_word,
                                             input logic [3:0]  be);
        logic [31:0] merged;
        merged = old_word;
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                merged[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return merged;
    endfunction

    assign reg_addr = ctrl_add_i[7:0];
    assign is_read  = (ctrl_type_i == CTRL_READ);

    always_comb begin : proc_decode
        ctrl_gnt_o     = ctrl_req_i;
        launch_valid_o = 1'b0;
        rdata_d        = '0;
        src_d          = src_q;
        dst_d          = dst_q;
        num_d          = num_q;
        conf_d         = conf_q;
        if (ctrl_req_i) begin
            case (reg_addr)
                REG_SRC: begin
                    if (is_read) begin
                        rdata_d = src_q;
                    end else begin
                        src_d = merge_be(src_q, ctrl_data_i, ctrl_be_i);
                    end
                end
                REG_DST: begin
                    if (is_read) begin
                        rdata_d = dst_q;
                    end else begin
                        dst_d = merge_be(dst_q, ctrl_data_i, ctrl_be_i);
                    end
                end
                REG_NUM: begin
                    if (is_read) begin
                        rdata_d = num_q;
                    end else begin
                        num_d = merge_be(num_q, ctrl_data_i, ctrl_be_i);
                    end
                end
                REG_CONF: begin
                    if (is_read) begin
                        rdata_d = {15'h0000, busy_i, 13'h0000, conf_q};
                    end else begin
                        conf_d = ctrl_data_i[2:0];
                    end
                end
                REG_NEXT_ID: begin
                    // empty transfer answers 0 at once and launches nothing
                    if (is_read && num_q != '0) begin
                        launch_valid_o = 1'b1;
                        ctrl_gnt_o     = launch_grant_i;
                        rdata_d        = {{IdPad{1'b0}}, next_id_i};
                    end
                end
                REG_DONE_ID: begin
                    if (is_read) begin
                        rdata_d = {{IdPad{1'b0}}, done_id_i};
                    end
                end
                default: begin
                    rdata_d = '0;
                end
            endcase
        end
    end

    assign valid_d = ctrl_req_i & ctrl_gnt_o;

    always_ff @(posedge clk_i or negedge rst_ni) begin : proc_state
        if (!rst_ni) begin
            src_q   <= '0;
            dst_q   <= '0;
            num_q   <= '0;
            conf_q  <= ConfResetValue;
            rdata_q <= '0;
            valid_q <= 1'b0;
        end else begin
            src_q   <= src_d;
            dst_q   <= dst_d;
            num_q   <= num_d;
            conf_q  <= conf_d;
            rdata_q <= rdata_d;
            valid_q <= valid_d;
        end
    end

    assign ctrl_valid_o = valid_q;
    assign ctrl_data_o  = rdata_q;

    assign descr_o.num_bytes = num_q;
    assign descr_o.dst_addr  = dst_q;
    assign descr_o.src_addr  = src_q;
    assign descr_o.decouple  = conf_q[0];
    assign descr_o.deburst   = conf_q[1];
    assign descr_o.serialize = conf_q[2];

    // the backend must never see an empty job
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        launch_grant_i |-> descr_o.num_bytes != '0)
        else $error("grant for a launch with zero byte count");

endmodule

//--- verilog/dma_descr_arbiter.sv
`timescale 1ns/1ps

module dma_descr_arbiter #(
    parameter int unsigned NumPes   = 2,
    parameter int unsigned IdxWidth = (NumPes > 1) ? $clog2(NumPes) : 1
)(
    input  logic                                         clk_i,
    input  logic                                         rst_ni,
    input  logic [NumPes-1:0]                            valid_i,
    input  dma_frontend_pkg::transf_descr_t [NumPes-1:0] descr_i,
    input  logic                                         ready_i,
    output logic [NumPes-1:0]                            grant_o,
    output logic                                         valid_o,
    output dma_frontend_pkg::transf_descr_t              descr_o
);

    logic [IdxWidth-1:0] last_q;
    logic [IdxWidth-1:0] win_idx;
    logic                found;

    // search starts one past the previous winner
    always_comb begin : proc_pick
        int unsigned cand;
        found   = 1'b0;
        win_idx = last_q;
        for (int unsigned i = 1; i <= NumPes; i++) begin
            cand = (last_q + i) % NumPes;
            if (!found && valid_i[cand]) begin
                found   = 1'b1;
                win_idx = IdxWidth'(cand);
            end
        end
    end

    always_comb begin : proc_grant
        grant_o = '0;
        if (found && ready_i) begin
            grant_o[win_idx] = 1'b1;
        end
    end

    assign valid_o = found;
    assign descr_o = descr_i[win_idx];

    // PE 0 has first priority out of reset
    always_ff @(posedge clk_i or negedge rst_ni) begin : proc_pointer
        if (!rst_ni) begin
            last_q <= IdxWidth'(NumPes - 1);
        end else if (found && ready_i) begin
            last_q <= win_idx;
        end
    end

    // a waiting PE keeps its launch up until it wins
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        (valid_i & ~grant_o) != '0 |=> ($past(valid_i & ~grant_o) & ~valid_i) == '0)
        else $error("launch request withdrawn before its grant");

endmodule

//--- verilog/dma_transfer_id_gen.sv
`timescale 1ns/1ps

module dma_transfer_id_gen (
    input  logic                                         clk_i,
    input  logic                                         rst_ni,
    input  logic                                         issue_i,
    input  logic                                         complete_i,
    output logic [dma_frontend_pkg::TransferIdWidth-1:0] next_id_o,
    output logic [dma_frontend_pkg::TransferIdWidth-1:0] done_id_o
);

    // id 0 is reserved for the empty launch answer
    always_ff @(posedge clk_i or negedge rst_ni) begin : proc_next_id
        if (!rst_ni) begin
            next_id_o <= 1;
        end else if (issue_i) begin
            next_id_o <= next_id_o + 1'b1;
        end
    end

    // single in-order engine, so a completion count is the last finished id
    always_ff @(posedge clk_i or negedge rst_ni) begin : proc_done_id
        if (!rst_ni) begin
            done_id_o <= '0;
        end else if (complete_i) begin
            done_id_o <= done_id_o + 1'b1;
        end
    end

    // engine cannot finish more jobs than were issued
    assert property (@(posedge clk_i) disable iff (!rst_ni) done_id_o < next_id_o)
        else $error("done id overtook next id");

endmodule

//--- verilog/dma_copy_engine.sv
`timescale 1ns/1ps

module dma_copy_engine #(
    parameter int unsigned MemWords  = 256,
    parameter int unsigned AddrWidth = $clog2(MemWords)
)(
    input  logic                            clk_i,
    input  logic                            rst_ni,
    input  logic                            valid_i,
    input  dma_frontend_pkg::transf_descr_t descr_i,
    output logic                            ready_o,
    output logic                            busy_o,
    output logic                            done_o,
    input  logic                            mem_stall_i,
    output logic                            mem_req_o,
    output logic                            mem_we_o,
    output logic [AddrWidth-1:0]            mem_addr_o,
    output logic [31:0]                     mem_wdata_o,
    input  logic [31:0]                     mem_rdata_i
);

    import dma_frontend_pkg::*;

    eng_state_e           state_d, state_q;
    logic [AddrWidth-1:0] src_d, src_q;
    logic [AddrWidth-1:0] dst_d, dst_q;
    logic [31:0]          left_d, left_q;
    // read data shows up the cycle after the read is accepted
    logic                 fresh_q;
    logic [31:0]          word_q;

    always_comb begin : proc_fsm
        state_d = state_q;
        src_d   = src_q;
        dst_d   = dst_q;
        left_d  = left_q;
        done_o  = 1'b0;
        case (state_q)
            ENG_IDLE: begin
                if (valid_i) begin
                    // byte addresses to word addresses
                    src_d   = descr_i.src_addr[AddrWidth+1:2];
                    dst_d   = descr_i.dst_addr[AddrWidth+1:2];
                    left_d  = descr_i.num_bytes;
                    state_d = ENG_READ;
                end
            end
            ENG_READ: begin
                if (!mem_stall_i) begin
                    state_d = ENG_WRITE;
                end
            end
            ENG_WRITE: begin
                if (!mem_stall_i) begin
                    src_d  = src_q + 1'b1;
                    dst_d  = dst_q + 1'b1;
                    left_d = left_q - 32'd4;
                    if (left_q <= 32'd4) begin
                        done_o  = 1'b1;
                        state_d = ENG_IDLE;
                    end else begin
                        state_d = ENG_READ;
                    end
                end
            end
            default: begin
                state_d = ENG_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin : proc_regs
        if (!rst_ni) begin
            state_q <= ENG_IDLE;
            src_q   <= '0;
            dst_q   <= '0;
            left_q  <= '0;
            fresh_q <= 1'b0;
        end else begin
            state_q <= state_d;
            src_q   <= src_d;
            dst_q   <= dst_d;
            left_q  <= left_d;
            fresh_q <= (state_q == ENG_READ) && !mem_stall_i;
        end
    end

    // hold the word across write stalls
    always_ff @(posedge clk_i) begin : proc_word
        if (fresh_q) begin
            word_q <= mem_rdata_i;
        end
    end

    assign ready_o     = (state_q == ENG_IDLE);
    assign busy_o      = (state_q != ENG_IDLE);
    assign mem_req_o   = (state_q != ENG_IDLE);
    assign mem_we_o    = (state_q == ENG_WRITE);
    assign mem_addr_o  = (state_q == ENG_WRITE) ? dst_q : src_q;
    assign mem_wdata_o = fresh_q ? mem_rdata_i : word_q;

endmodule

//--- verilog/dma_scratch_mem.sv
`timescale 1ns/1ps

module dma_scratch_mem #(
    parameter int unsigned MemWords  = 256,
    parameter int unsigned AddrWidth = $clog2(MemWords)
)(
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 ext_req_i,
    input  logic                 ext_we_i,
    input  logic [AddrWidth-1:0] ext_addr_i,
    input  logic [31:0]          ext_wdata_i,
    output logic [31:0]          ext_rdata_o,
    input  logic                 eng_req_i,
    input  logic                 eng_we_i,
    input  logic [AddrWidth-1:0] eng_addr_i,
    input  logic [31:0]          eng_wdata_i,
    output logic [31:0]          eng_rdata_o,
    output logic                 eng_stall_o
);

    logic [31:0] mem_q [MemWords];
    logic        eng_go;

    // external port always wins, engine retries
    assign eng_stall_o = ext_req_i & eng_req_i;
    assign eng_go      = eng_req_i & ~ext_req_i;

    always_ff @(posedge clk_i) begin : proc_array
        if (ext_req_i && ext_we_i) begin
            mem_q[ext_addr_i] <= ext_wdata_i;
        end else if (eng_go && eng_we_i) begin
            mem_q[eng_addr_i] <= eng_wdata_i;
        end
    end

    // each port keeps its last read word
    always_ff @(posedge clk_i or negedge rst_ni) begin : proc_rdata
        if (!rst_ni) begin
            ext_rdata_o <= '0;
            eng_rdata_o <= '0;
        end else begin
            if (ext_req_i && !ext_we_i) begin
                ext_rdata_o <= mem_q[ext_addr_i];
            end
            if (eng_go && !eng_we_i) begin
                eng_rdata_o <= mem_q[eng_addr_i];
            end
        end
    end

endmodule

//--- verilog/dma_cluster_frontend.sv
`timescale 1ns/1ps

module dma_cluster_frontend #(
    parameter int unsigned NumPes   = 2,
    parameter int unsigned MemWords = 256
)(
    input  logic                                    clk_i,
    input  logic                                    rst_ni,
    input  logic [NumPes-1:0]                       ctrl_req_i,
    input  dma_frontend_pkg::ctrl_op_e [NumPes-1:0] ctrl_type_i,
    input  logic [NumPes-1:0][3:0]                  ctrl_be_i,
    input  logic [NumPes-1:0][31:0]                 ctrl_add_i,
    input  logic [NumPes-1:0][31:0]                 ctrl_data_i,
    output logic [NumPes-1:0]                       ctrl_gnt_o,
    output logic [NumPes-1:0]                       ctrl_valid_o,
    output logic [NumPes-1:0][31:0]                 ctrl_data_o,
    input  logic                                    mem_req_i,
    input  logic                                    mem_we_i,
    input  logic [$clog2(MemWords)-1:0]             mem_addr_i,
    input  logic [31:0]                             mem_wdata_i,
    output logic [31:0]                             mem_rdata_o,
    output logic                                    busy_o
);

    import dma_frontend_pkg::*;

    localparam int unsigned AddrWidth = $clog2(MemWords);

    logic [NumPes-1:0]                launch_valid;
    logic [NumPes-1:0]                launch_grant;
    transf_descr_t [NumPes-1:0]       pe_descr;
    transf_descr_t                    arb_descr;
    logic                             arb_valid;
    logic                             eng_ready;
    logic                             eng_done;
    logic [TransferIdWidth-1:0]       next_id;
    logic [TransferIdWidth-1:0]       done_id;
    logic                             eng_req;
    logic                             eng_we;
    logic [AddrWidth-1:0]             eng_addr;
    logic [31:0]                      eng_wdata;
    logic [31:0]                      eng_rdata;
    logic                             eng_stall;

    // one register file per PE, all sharing the id counters
    for (genvar pe = 0; pe < NumPes; pe++) begin : gen_regs
        dma_frontend_regs regs_inst (
            .clk_i          (clk_i),
            .rst_ni         (rst_ni),
            .ctrl_req_i     (ctrl_req_i[pe]),
            .ctrl_type_i    (ctrl_type_i[pe]),
            .ctrl_be_i      (ctrl_be_i[pe]),
            .ctrl_add_i     (ctrl_add_i[pe]),
            .ctrl_data_i    (ctrl_data_i[pe]),
            .ctrl_gnt_o     (ctrl_gnt_o[pe]),
            .ctrl_valid_o   (ctrl_valid_o[pe]),
            .ctrl_data_o    (ctrl_data_o[pe]),
            .next_id_i      (next_id),
            .done_id_i      (done_id),
            .busy_i         (busy_o),
            .launch_grant_i (launch_grant[pe]),
            .launch_valid_o (launch_valid[pe]),
            .descr_o        (pe_descr[pe])
        );
    end

    dma_descr_arbiter #(
        .NumPes (NumPes)
    ) arbiter_inst (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .valid_i (launch_valid),
        .descr_i (pe_descr),
        .ready_i (eng_ready),
        .grant_o (launch_grant),
        .valid_o (arb_valid),
        .descr_o (arb_descr)
    );

    dma_transfer_id_gen id_gen_inst (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .issue_i    (arb_valid & eng_ready),
        .complete_i (eng_done),
        .next_id_o  (next_id),
        .done_id_o  (done_id)
    );

    dma_copy_engine #(
        .MemWords (MemWords)
    ) engine_inst (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .valid_i     (arb_valid),
        .descr_i     (arb_descr),
        .ready_o     (eng_ready),
        .busy_o      (busy_o),
        .done_o      (eng_done),
        .mem_stall_i (eng_stall),
        .mem_req_o   (eng_req),
        .mem_we_o    (eng_we),
        .mem_addr_o  (eng_addr),
        .mem_wdata_o (eng_wdata),
        .mem_rdata_i (eng_rdata)
    );

    dma_scratch_mem #(
        .MemWords (MemWords)
    ) mem_inst (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .ext_req_i   (mem_req_i),
        .ext_we_i    (mem_we_i),
        .ext_addr_i  (mem_addr_i),
        .ext_wdata_i (mem_wdata_i),
        .ext_rdata_o (mem_rdata_o),
        .eng_req_i   (eng_req),
        .eng_we_i    (eng_we),
        .eng_addr_i  (eng_addr),
        .eng_wdata_i (eng_wdata),
        .eng_rdata_o (eng_rdata),
        .eng_stall_o (eng_stall)
    );

endmodule

//--- dv/tb_dma_cluster_frontend.sv
`timescale 1ns/1ps

module tb_dma_cluster_frontend;

    import dma_frontend_pkg::*;

    localparam int unsigned NumPes       = 2;
    localparam int unsigned MemWords     = 256;
    localparam int unsigned MemAddrWidth = $clog2(MemWords);

    logic                          clk_i;
    logic                          rst_ni;
    logic [NumPes-1:0]             ctrl_req;
    ctrl_op_e [NumPes-1:0]         ctrl_type;
    logic [NumPes-1:0][3:0]        ctrl_be;
    logic [NumPes-1:0][31:0]       ctrl_add;
    logic [NumPes-1:0][31:0]       ctrl_wdata;
    logic [NumPes-1:0]             ctrl_gnt;
    logic [NumPes-1:0]             ctrl_valid;
    logic [NumPes-1:0][31:0]       ctrl_rdata;
    logic                          mem_req;
    logic                          mem_we;
    logic [MemAddrWidth-1:0]       mem_addr;
    logic [31:0]                   mem_wdata;
    logic [31:0]                   mem_rdata;
    logic                          busy;

    // one entry per stimulus line
    logic [7:0]  op_q[$];
    logic [31:0] idx_q[$];
    logic [31:0] off_q[$];
    logic [31:0] data_q[$];
    logic [31:0] be_q[$];
    logic [31:0] exp_q[$];

    int cycle_count = 0;
    int cycle_limit = 0;

    dma_cluster_frontend #(
        .NumPes   (NumPes),
        .MemWords (MemWords)
    ) dma_cluster_frontend_inst (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .ctrl_req_i   (ctrl_req),
        .ctrl_type_i  (ctrl_type),
        .ctrl_be_i    (ctrl_be),
        .ctrl_add_i   (ctrl_add),
        .ctrl_data_i  (ctrl_wdata),
        .ctrl_gnt_o   (ctrl_gnt),
        .ctrl_valid_o (ctrl_valid),
        .ctrl_data_o  (ctrl_rdata),
        .mem_req_i    (mem_req),
        .mem_we_i     (mem_we),
        .mem_addr_i   (mem_addr),
        .mem_wdata_i  (mem_wdata),
        .mem_rdata_o  (mem_rdata),
        .busy_o       (busy)
    );

    initial begin : proc_clock
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin : proc_timeout
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("TESTBENCH FAILED");
            $fatal(1, "run stopped by cycle limit");
        end
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped on error");
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("[FAIL] %0t ns: %s, got %h, expected %h", $time, what, got, exp);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped on first mismatch");
    endtask

    task automatic check_reg(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            report_mismatch(what, got, exp);
        end
    endtask

    task automatic check_mem_word(input logic [31:0] got, input logic [31:0] exp,
                                  input string what);
        if (got !== exp) begin
            report_mismatch(what, got, exp);
        end
    endtask

    task automatic check_id(input logic [TransferIdWidth-1:0] got,
                            input logic [TransferIdWidth-1:0] exp, input string what);
        if (got !== exp) begin
            report_mismatch(what, 32'(got), 32'(exp));
        end
    endtask

    // '#' lines are comments, all other lines hold six fields
    task automatic load_stimulus();
        int          fd;
        int          code;
        int          c;
        logic [7:0]  op_char;
        logic [31:0] f_idx, f_off, f_data, f_be, f_exp;
        fd = $fopen("dv/dma_stim.txt", "r");
        if (fd == 0) begin
            stop_on_error("could not open the stimulus file dv/dma_stim.txt");
        end
        while (1) begin
            code = $fscanf(fd, " %c", op_char);
            if (code != 1) begin
                break;
            end
            if (op_char == "#") begin
                c = 0;
                while (c != "\n" && c != -1) begin
                    c = $fgetc(fd);
                end
                continue;
            end
            code = $fscanf(fd, "%h %h %h %h %h", f_idx, f_off, f_data, f_be, f_exp);
            if (code != 5) begin
                stop_on_error("malformed line in the stimulus file");
            end
            op_q.push_back(op_char);
            idx_q.push_back(f_idx);
            off_q.push_back(f_off);
            data_q.push_back(f_data);
            be_q.push_back(f_be);
            exp_q.push_back(f_exp);
        end
        $fclose(fd);
    endtask

    // called at posedge+1, returns at posedge+1 after the response
    task automatic ctrl_access(input int pe, input ctrl_op_e op, input logic [7:0] offset,
                               input logic [31:0] wdata, input logic [3:0] be,
                               output logic [31:0] rdata);
        logic granted;
        ctrl_req[pe]   = 1'b1;
        ctrl_type[pe]  = op;
        ctrl_be[pe]    = be;
        ctrl_add[pe]   = {24'h000000, offset};
        ctrl_wdata[pe] = wdata;
        granted = 1'b0;
        while (!granted) begin
            #1;
            granted = ctrl_gnt[pe];
            @(posedge clk_i);
            #1;
        end
        ctrl_req[pe] = 1'b0;
        if (!ctrl_valid[pe]) begin
            stop_on_error($sformatf("PE %0d got no valid pulse one cycle after its grant", pe));
        end
        rdata = ctrl_rdata[pe];
    endtask

    task automatic launch_check(input int pe, input logic [TransferIdWidth-1:0] exp_id);
        logic [31:0] rdata;
        ctrl_access(pe, CTRL_READ, REG_NEXT_ID, '0, '0, rdata);
        check_id(rdata[TransferIdWidth-1:0], exp_id, $sformatf("launch id on PE %0d", pe));
    endtask

    task automatic poll_done_id(input int pe, input logic [TransferIdWidth-1:0] target);
        logic [31:0]                rdata;
        logic [TransferIdWidth-1:0] seen;
        ctrl_access(pe, CTRL_READ, REG_DONE_ID, '0, '0, rdata);
        seen = rdata[TransferIdWidth-1:0];
        while (seen != target) begin
            if (seen > target) begin
                check_id(seen, target, "done id ran past the expected id");
            end
            ctrl_access(pe, CTRL_READ, REG_DONE_ID, '0, '0, rdata);
            seen = rdata[TransferIdWidth-1:0];
        end
        // upper bits of the done id register stay zero
        check_reg(rdata, 32'(target), $sformatf("done id register on PE %0d", pe));
    endtask

    task automatic mem_write(input logic [MemAddrWidth-1:0] addr, input logic [31:0] data);
        mem_req   = 1'b1;
        mem_we    = 1'b1;
        mem_addr  = addr;
        mem_wdata = data;
        @(posedge clk_i);
        #1;
        mem_req = 1'b0;
        mem_we  = 1'b0;
    endtask

    // one cycle read latency
    task automatic mem_read(input logic [MemAddrWidth-1:0] addr, output logic [31:0] data);
        mem_req  = 1'b1;
        mem_we   = 1'b0;
        mem_addr = addr;
        @(posedge clk_i);
        #1;
        mem_req = 1'b0;
        data    = mem_rdata;
    endtask

    initial begin : proc_main
        logic [31:0] rdata;
        rst_ni     = 1'b0;
        ctrl_req   = '0;
        ctrl_be    = '0;
        ctrl_add   = '0;
        ctrl_wdata = '0;
        for (int pe = 0; pe < NumPes; pe++) begin
            ctrl_type[pe] = CTRL_WRITE;
        end
        mem_req   = 1'b0;
        mem_we    = 1'b0;
        mem_addr  = '0;
        mem_wdata = '0;
        load_stimulus();
        cycle_limit = 40 * op_q.size() + 200;
        repeat (4) @(posedge clk_i);
        #1 rst_ni = 1'b1;
        @(posedge clk_i);
        #1;
        check_reg(32'(busy), '0, "busy after reset");
        check_reg(32'(ctrl_valid), '0, "ctrl valid after reset");
        for (int i = 0; i < op_q.size(); i++) begin
            case (op_q[i])
                "W": begin
                    ctrl_access(idx_q[i], CTRL_WRITE, off_q[i][7:0], data_q[i], be_q[i][3:0],
                                rdata);
                    check_reg(rdata, '0, $sformatf("entry %0d write response data", i));
                end
                "R": begin
                    ctrl_access(idx_q[i], CTRL_READ, off_q[i][7:0], '0, '0, rdata);
                    check_reg(rdata, exp_q[i], $sformatf("entry %0d read of offset %h on PE %0d",
                              i, off_q[i][7:0], idx_q[i]));
                end
                "L": launch_check(idx_q[i], exp_q[i][TransferIdWidth-1:0]);
                "P": poll_done_id(idx_q[i], exp_q[i][TransferIdWidth-1:0]);
                "M": mem_write(idx_q[i][MemAddrWidth-1:0], data_q[i]);
                "C": begin
                    mem_read(idx_q[i][MemAddrWidth-1:0], rdata);
                    check_mem_word(rdata, exp_q[i], $sformatf("memory word %h",
                                   idx_q[i][MemAddrWidth-1:0]));
                end
                "D": begin
                    // both PEs request in the same cycle
                    fork
                        launch_check(idx_q[i], data_q[i][TransferIdWidth-1:0]);
                        launch_check(off_q[i], exp_q[i][TransferIdWidth-1:0]);
                    join
                end
                default: begin
                    stop_on_error($sformatf("unknown operation code %c in stimulus entry %0d",
                                  op_q[i], i));
                end
            endcase
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

//--- dv/dma_stim.txt
# columns: op idx off data be exp, all hex; idx is the PE for W R L P, a word address for M C
# D launches on PE idx and PE off together, expecting id data on idx and id exp on off
W 0 00 11223344 f 0
R 0 00 0 0 11223344
W 0 00 aabbccdd 5 0
R 0 00 0 0 11bb33dd
W 0 08 00000100 f 0
W 0 08 ffffffff 2 0
R 0 08 0 0 0000ff00
R 0 30 0 0 0
R 0 04 0 0 0
R 0 18 0 0 5
W 0 18 2 1 0
R 0 18 0 0 2
R 1 18 0 0 5
R 0 10 0 0 0
L 0 20 0 0 0
R 0 28 0 0 0
M 10 0 cafe0001 0 0
M 11 0 cafe0002 0 0
M 12 0 cafe0003 0 0
M 13 0 cafe0004 0 0
M 44 0 5a5a5a5a 0 0
W 0 00 00000040 f 0
W 0 08 00000100 f 0
W 0 10 00000010 f 0
L 0 20 0 0 1
R 0 18 0 0 00010002
P 0 28 0 0 1
R 0 18 0 0 2
C 40 0 0 0 cafe0001
C 41 0 0 0 cafe0002
C 42 0 0 0 cafe0003
C 43 0 0 0 cafe0004
C 44 0 0 0 5a5a5a5a
M 20 0 beef0001 0 0
M 21 0 beef0002 0 0
W 1 00 00000080 f 0
W 1 08 00000200 f 0
W 1 10 00000008 f 0
L 1 20 0 0 2
P 1 28 0 0 2
C 80 0 0 0 beef0001
C 81 0 0 0 beef0002
W 0 08 00000300 f 0
W 0 10 0000000c f 0
W 1 08 00000280 f 0
D 0 1 3 0 4
P 0 28 0 0 4
R 1 28 0 0 4
C c0 0 0 0 cafe0001
C c1 0 0 0 cafe0002
C c2 0 0 0 cafe0003
C a0 0 0 0 beef0001
C a1 0 0 0 beef0002

//--- sim.f
verilog/dma_frontend_pkg.sv
verilog/dma_frontend_regs.sv
verilog/dma_descr_arbiter.sv
verilog/dma_transfer_id_gen.sv
verilog/dma_copy_engine.sv
verilog/dma_scratch_mem.sv
verilog/dma_cluster_frontend.sv
dv/tb_dma_cluster_frontend.sv

//--- Bender.yml
package:
  name: dma_cluster_frontend

sources:
  - verilog/dma_frontend_pkg.sv
  - verilog/dma_frontend_regs.sv
  - verilog/dma_descr_arbiter.sv
  - verilog/dma_transfer_id_gen.sv
  - verilog/dma_copy_engine.sv
  - verilog/dma_scratch_mem.sv
  - verilog/dma_cluster_frontend.sv
  - target: test
    files:
      - dv/tb_dma_cluster_frontend.sv
